/* Bender.yml */
package:
  name: rasterbars

sources:
  - logic/rb_pkg.sv
  - logic/display_timing.sv
  - logic/bar_colour_gen.sv
  - logic/pixel_output.sv
  - logic/rasterbars_top.sv
  - target: simulation
    files:
      - tb/tb_rasterbars.sv

/* filelist.f */
logic/rb_pkg.sv
logic/display_timing.sv
logic/bar_colour_gen.sv
logic/pixel_output.sv
logic/rasterbars_top.sv
tb/tb_rasterbars.sv

/* logic/bar_colour_gen.sv */
////////////////////////////////////////
// raster bar colour, stepped once per line;
// settings latched at the frame wrap
////////////////////////////////////////

module bar_colour_gen (
	input  wire logic         clk_pix,  // pixel clock
	input  wire logic         arst_n,   // async reset, active low
	input  rb_pkg::beam_t     beam,     // from display timing
	input  rb_pkg::bar_cfg_t  bar_cfg,  // level input, sampled at frame wrap
	output rb_pkg::rgb565_t   bar_colr  // colour of the current line
);

	rb_pkg::bar_cfg_t         cfg_q;     // settings for this frame
	rb_pkg::rgb565_t          colr_q;    // line colour register
	rb_pkg::rgb565_t          colr_nxt;  // colour one step on
	logic [rb_pkg::cnt_w-1:0] cnt_line;  // lines shown in this colour
	logic [rb_pkg::cnt_w-1:0] cnt_colr;  // advances in this run
	logic                     bar_inc;   // 1 brighter, 0 darker
	logic                     line_stb;  // start of horizontal blanking
	logic                     frame_stb; // same, on the last frame line
	logic                     colr_done; // group of lines complete
	logic                     run_done;  // last advance of the run

	always_comb begin
		line_stb  = (beam.sx == rb_pkg::coord_w'(rb_pkg::h_res));
		frame_stb = line_stb && (beam.sy == rb_pkg::coord_w'(rb_pkg::v_total - 1));
		colr_done = (cnt_line == cfg_q.line_num - rb_pkg::cnt_w'(1));
		run_done  = (cnt_colr == cfg_q.colr_num - rb_pkg::cnt_w'(1));
	end

	// whole word wraps, channels carry into each other
	always_comb begin
		if (bar_inc) begin
			colr_nxt = rb_pkg::rgb565_t'(colr_q + rb_pkg::colr_step);
		end else begin
			colr_nxt = rb_pkg::rgb565_t'(colr_q - rb_pkg::colr_step);
		end
	end

	always_ff @(posedge clk_pix or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q    <= '0;  // zero settings until first wrap
			colr_q   <= '0;
			cnt_line <= '0;
			cnt_colr <= '0;
			bar_inc  <= 1'b1;
		end else if (frame_stb) begin
			cfg_q    <= bar_cfg;             // new frame settings
			colr_q   <= bar_cfg.start_colr;  // shown on line 0
			cnt_line <= '0;
			cnt_colr <= '0;
			bar_inc  <= 1'b1;                // rise first
		end else if (line_stb) begin
			if (colr_done) begin
				cnt_line <= '0;
				if (run_done) begin
					cnt_colr <= '0;
					bar_inc  <= ~bar_inc;  // turn, colour holds
				end else begin
					cnt_colr <= cnt_colr + 1'b1;
					colr_q   <= colr_nxt;
				end
			end else begin
				cnt_line <= cnt_line + 1'b1;
			end
		end
	end

	assign bar_colr = colr_q;

endmodule

/* logic/display_timing.sv */
////////////////////////////////////////
// beam generator for the 480x272 panel; counts
// pixels and lines and registers position and syncs
////////////////////////////////////////

module display_timing (
	input  wire logic    clk_pix,  // pixel clock
	input  wire logic    arst_n,   // async reset, active low
	output rb_pkg::beam_t beam     // position, syncs and de, registered
);

	logic [rb_pkg::coord_w-1:0] x_cnt;  // free running column
	logic [rb_pkg::coord_w-1:0] y_cnt;  // free running line
	logic                       line_end;   // last column of line
	logic                       frame_end;  // last line of frame
	logic                       hsync_nxt;
	logic                       vsync_nxt;
	logic                       de_nxt;

	// decode the counters before they go into the beam register
	always_comb begin
		line_end  = (x_cnt == rb_pkg::coord_w'(rb_pkg::h_total - 1));
		frame_end = (y_cnt == rb_pkg::coord_w'(rb_pkg::v_total - 1));
		hsync_nxt = (x_cnt >= rb_pkg::coord_w'(rb_pkg::h_sync_sta) &&
		             x_cnt <  rb_pkg::coord_w'(rb_pkg::h_sync_end))
		            ? rb_pkg::sync_on : ~rb_pkg::sync_on;
		vsync_nxt = (y_cnt >= rb_pkg::coord_w'(rb_pkg::v_sync_sta) &&
		             y_cnt <  rb_pkg::coord_w'(rb_pkg::v_sync_end))
		            ? rb_pkg::sync_on : ~rb_pkg::sync_on;
		de_nxt    = (x_cnt < rb_pkg::coord_w'(rb_pkg::h_res)) &&
		            (y_cnt < rb_pkg::coord_w'(rb_pkg::v_res));
	end

	// column and line counters
	always_ff @(posedge clk_pix or negedge arst_n) begin
		if (!arst_n) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (line_end) begin
			x_cnt <= '0;  // wrap to column 0
			if (frame_end) begin
				y_cnt <= '0;  // new frame
			end else begin
				y_cnt <= y_cnt + 1'b1;
			end
		end else begin
			x_cnt <= x_cnt + 1'b1;
		end
	end

	// one register stage so coordinates and syncs stay aligned
	always_ff @(posedge clk_pix or negedge arst_n) begin
		if (!arst_n) begin
			beam <= '{
				sx:    '0,
				sy:    '0,
				hsync: ~rb_pkg::sync_on,  // idle high
				vsync: ~rb_pkg::sync_on,
				de:    1'b0
			};
		end else begin
			beam.sx    <= x_cnt;
			beam.sy    <= y_cnt;
			beam.hsync <= hsync_nxt;
			beam.vsync <= vsync_nxt;
			beam.de    <= de_nxt;
		end
	end

endmodule

/* logic/pixel_output.sv */
////////////////////////////////////////
// panel output register; black in blanking
////////////////////////////////////////

module pixel_output (
	input  wire logic       clk_pix,    // pixel clock
	input  wire logic       arst_n,     // async reset, active low
	input  rb_pkg::beam_t   beam,       // position and syncs
	input  rb_pkg::rgb565_t bar_colr,   // colour of current line
	output logic            lcd_hsync,  // active low
	output logic            lcd_vsync,  // active low
	output logic            lcd_de,     // data enable
	output rb_pkg::rgb565_t lcd_colr    // 16-bit panel data
);

	rb_pkg::rgb565_t colr_nxt;  // colour gated by de

	// panel must see black outside the active area
	always_comb begin
		if (beam.de) begin
			colr_nxt = bar_colr;
		end else begin
			colr_nxt = '0;
		end
	end

	always_ff @(posedge clk_pix or negedge arst_n) begin
		if (!arst_n) begin
			lcd_hsync <= ~rb_pkg::sync_on;  // syncs idle
			lcd_vsync <= ~rb_pkg::sync_on;
			lcd_de    <= 1'b0;
			lcd_colr  <= '0;
		end else begin
			lcd_hsync <= beam.hsync;  // one cycle behind beam
			lcd_vsync <= beam.vsync;
			lcd_de    <= beam.de;
			lcd_colr  <= colr_nxt;
		end
	end

endmodule

/* logic/rasterbars_top.sv */
////////////////////////////////////////
// raster bars on a 480x272 RGB565 panel;
// clock and reset come from the board level
////////////////////////////////////////

module rasterbars_top (
	input  wire logic        clk_pix,    // pixel clock
	input  wire logic        arst_n,     // async reset, active low
	input  rb_pkg::bar_cfg_t bar_cfg,    // bar settings, taken per frame
	output logic             lcd_hsync,  // panel hsync, active low
	output logic             lcd_vsync,  // panel vsync, active low
	output logic             lcd_de,     // panel data enable
	output rb_pkg::rgb565_t  lcd_colr    // panel colour
);

	rb_pkg::beam_t   beam;      // timing to bar and output stages
	rb_pkg::rgb565_t bar_colr;  // line colour

	// beam position and syncs
	display_timing i_display_timing (
		.clk_pix (clk_pix),
		.arst_n  (arst_n),
		.beam    (beam)
	);

	// colour rule per line
	bar_colour_gen i_bar_colour_gen (
		.clk_pix  (clk_pix),
		.arst_n   (arst_n),
		.beam     (beam),
		.bar_cfg  (bar_cfg),
		.bar_colr (bar_colr)
	);

	// registered panel pins
	pixel_output i_pixel_output (
		.clk_pix   (clk_pix),
		.arst_n    (arst_n),
		.beam      (beam),
		.bar_colr  (bar_colr),
		.lcd_hsync (lcd_hsync),
		.lcd_vsync (lcd_vsync),
		.lcd_de    (lcd_de),
		.lcd_colr  (lcd_colr)
	);

endmodule

/* logic/rb_pkg.sv */
////////////////////////////////////////
// shared geometry, colour and beam types for the
// raster bar subsystem; referenced by package::name
////////////////////////////////////////

package rb_pkg;

	localparam int coord_w = 10;  // screen coordinate bits
	localparam int cnt_w   = 4;   // step and line counter bits

	// active area of the 480x272 panel
	localparam int h_res = 480;
	localparam int v_res = 272;

	// horizontal blanking
	localparam int h_fp   = 2;   // front porch
	localparam int h_sync = 41;  // sync pulse
	localparam int h_bp   = 2;   // back porch

	// vertical blanking
	localparam int v_fp   = 2;
	localparam int v_sync = 10;
	localparam int v_bp   = 2;

	// full line and frame, blanking included (525 x 286)
	localparam int h_total = h_res + h_fp + h_sync + h_bp;
	localparam int v_total = v_res + v_fp + v_sync + v_bp;

	// sync pulse windows, end is first position after the pulse
	localparam int h_sync_sta = h_res + h_fp;
	localparam int h_sync_end = h_sync_sta + h_sync;
	localparam int v_sync_sta = v_res + v_fp;
	localparam int v_sync_end = v_sync_sta + v_sync;

	localparam logic sync_on = 1'b0;  // both syncs active low

	// +1 in every channel, applied to the whole word
	localparam logic [15:0] colr_step = {5'd1, 6'd1, 5'd1};

	typedef struct packed {
		logic [4:0] r;  // red
		logic [5:0] g;  // green, one bit wider
		logic [4:0] b;  // blue
	} rgb565_t;

	// beam position and panel control, one per pixel clock
	typedef struct packed {
		logic [coord_w-1:0] sx;  // column
		logic [coord_w-1:0] sy;  // line
		logic               hsync;  // active low
		logic               vsync;  // active low
		logic               de;     // active area
	} beam_t;

	// bar settings, taken once per frame
	typedef struct packed {
		rgb565_t          start_colr;  // colour of line 0
		logic [cnt_w-1:0] colr_num;    // steps per bar, 1..15
		logic [cnt_w-1:0] line_num;    // lines per colour, 1..15
	} bar_cfg_t;

endpackage

/* tb/rb_input.txt */
# c <start_colr hex> <colr_num> <line_num>   bar settings, one per frame
# s <line> <colour hex>   expected colour of that line in the frame above
c 1082 4 2
s 0 1082
s 2 18a3
s 6 28e5
s 8 28e5
s 10 20c4
s 14 1082
s 16 1082
s 150 28e5
s 271 1082
c ffff 3 5
s 0 ffff
s 5 0820
s 10 1041
s 15 1041
s 20 0820
s 25 ffff
s 271 ffff
c 0000 15 15
s 0 0000
s 15 0821
s 210 71ce
s 225 71ce
s 240 69ad
c 7bef 1 1
s 0 7bef
s 271 7bef

/* tb/tb_rasterbars.sv */
////////////////////////////////////////
// testbench for the raster bar top level; reads bar
// settings and line colours from tb/rb_input.txt
////////////////////////////////////////

module tb_rasterbars;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int frame_cyc = rb_pkg::h_total * rb_pkg::v_total;  // cycles per frame
	localparam int err_show  = 20;  // ERR lines printed at most

	logic             clk_pix;
	logic             arst_n;
	rb_pkg::bar_cfg_t bar_cfg;
	logic             lcd_hsync;
	logic             lcd_vsync;
	logic             lcd_de;
	rb_pkg::rgb565_t  lcd_colr;

	rb_pkg::bar_cfg_t cfgs [$];       // one per frame
	int               smp_frame [$];  // frame of each sample
	int               smp_line [$];   // line of each sample
	rb_pkg::rgb565_t  smp_colr [$];   // expected colour
	int               pass_cnt;
	int               fail_cnt;
	int               err_lines;      // ERR lines so far
	integer           seed;
	bit               run_ok;

	rasterbars_top i_dut (
		.clk_pix   (clk_pix),
		.arst_n    (arst_n),
		.bar_cfg   (bar_cfg),
		.lcd_hsync (lcd_hsync),
		.lcd_vsync (lcd_vsync),
		.lcd_de    (lcd_de),
		.lcd_colr  (lcd_colr)
	);

	initial begin
		clk_pix = 1'b0;
		forever #4 clk_pix = ~clk_pix;  // 8 ns period
	end

	task automatic check_colr(input string name, input rb_pkg::rgb565_t got,
	                          input rb_pkg::rgb565_t exp, inout int errs);
		if (got !== exp) begin
			errs++;
			if (err_lines < err_show) begin
				$display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
			end
			err_lines++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp,
	                           inout int errs);
		if (got !== exp) begin
			errs++;
			if (err_lines < err_show) begin
				$display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
			end
			err_lines++;
		end
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			pass_cnt++;
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: %0d mismatches", name, errs);
		end
	endtask

	// c lines open a frame and s lines belong to the last one opened
	task automatic load_stimulus(output bit ok);
		int               fd;
		int               code;
		int               frm;
		int               num_a;
		int               num_b;
		logic [15:0]      word;
		string            line;
		rb_pkg::bar_cfg_t cfg;
		ok  = 1'b1;
		frm = -1;
		fd  = $fopen("tb/rb_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/rb_input.txt for reading");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.getc(0) == "c") begin
					code = $sscanf(line, "c %h %d %d", word, num_a, num_b);
					if (code != 3 || num_a < 1 || num_a > 15 || num_b < 1 || num_b > 15) begin
						$display("bad configuration line in data file: %s", line);
						ok = 1'b0;
					end
					cfg.start_colr = word;
					cfg.colr_num   = num_a[3:0];
					cfg.line_num   = num_b[3:0];
					cfgs.push_back(cfg);
					frm++;
				end else if (code > 0 && line.getc(0) == "s") begin
					code = $sscanf(line, "s %d %h", num_a, word);
					if (code != 2 || frm < 0 || num_a < 0 || num_a >= rb_pkg::v_res) begin
						$display("bad sample line in data file: %s", line);
						ok = 1'b0;
					end else begin
						smp_frame.push_back(frm);
						smp_line.push_back(num_a);
						smp_colr.push_back(word);
					end
				end
			end
			$fclose(fd);
			if (cfgs.size() == 0) begin
				$display("data file holds no configuration");
				ok = 1'b0;
			end
		end
	endtask

	// outputs idle while reset is held and one cycle after
	task automatic test_reset_state();
		int errs;
		int n;
		errs = 0;
		for (n = 0; n < 5; n++) begin
			@(negedge clk_pix);
			check_level("lcd_de", lcd_de, 1'b0, errs);
			check_level("lcd_hsync", lcd_hsync, 1'b1, errs);
			check_level("lcd_vsync", lcd_vsync, 1'b1, errs);
			check_colr("lcd_colr", lcd_colr, '0, errs);
			if (n == 3) begin
				arst_n = 1'b1;  // released after 4 clock cycles
			end
		end
		report_test("reset state", errs);
	endtask

	task automatic wait_vsync_fall(output bit ok);
		logic prev;
		int   n;
		ok   = 1'b0;
		prev = lcd_vsync;
		for (n = 0; n < 2 * frame_cyc && !ok; n++) begin
			@(negedge clk_pix);
			if (prev === 1'b1 && lcd_vsync === 1'b0) begin
				ok = 1'b1;
			end
			prev = lcd_vsync;
		end
		if (!ok) begin
			$display("timeout: lcd_vsync did not fall within %0d cycles", 2 * frame_cyc);
		end
	endtask

	// starts on the vsync fall at column 0 of line v_res + v_fp
	task automatic walk_frame(input int f);
		int              x;
		int              y;
		int              n;
		int              k;
		int              geo_errs;
		int              blk_errs;
		int              col_errs;
		logic            exp_de;
		logic            exp_hs;
		logic            exp_vs;
		logic [31:0]     rnd;
		rb_pkg::rgb565_t exp_colr [rb_pkg::v_res];
		bit              has_exp [rb_pkg::v_res];
		geo_errs = 0;
		blk_errs = 0;
		col_errs = 0;
		for (k = 0; k < rb_pkg::v_res; k++) begin
			has_exp[k] = 1'b0;
		end
		for (k = 0; k < smp_frame.size(); k++) begin
			if (smp_frame[k] == f) begin
				has_exp[smp_line[k]]  = 1'b1;
				exp_colr[smp_line[k]] = smp_colr[k];
			end
		end
		x = 0;
		y = rb_pkg::v_res + rb_pkg::v_fp;
		for (n = 0; n < frame_cyc; n++) begin
			exp_de = (x < rb_pkg::h_res) && (y < rb_pkg::v_res);
			exp_hs = !(x >= rb_pkg::h_res + rb_pkg::h_fp &&
			           x <  rb_pkg::h_res + rb_pkg::h_fp + rb_pkg::h_sync);  // low in pulse
			exp_vs = !(y >= rb_pkg::v_res + rb_pkg::v_fp &&
			           y <  rb_pkg::v_res + rb_pkg::v_fp + rb_pkg::v_sync);
			check_level("lcd_de", lcd_de, exp_de, geo_errs);
			check_level("lcd_hsync", lcd_hsync, exp_hs, geo_errs);
			check_level("lcd_vsync", lcd_vsync, exp_vs, geo_errs);
			if (lcd_de !== 1'b1) begin
				check_colr("lcd_colr", lcd_colr, '0, blk_errs);  // black in blanking
			end else if (y < rb_pkg::v_res && has_exp[y]) begin
				check_colr("lcd_colr", lcd_colr, exp_colr[y], col_errs);
			end
			if (x == 0 && y == rb_pkg::v_res / 2) begin
				if (f + 1 < cfgs.size()) begin
					bar_cfg = cfgs[f + 1];  // mid frame change taken at next wrap
				end else begin
					rnd     = $random(seed);
					bar_cfg = rnd[23:0];    // must not reach this frame
				end
			end
			x++;
			if (x == rb_pkg::h_total) begin
				x = 0;
				y = (y == rb_pkg::v_total - 1) ? 0 : y + 1;
			end
			@(negedge clk_pix);
		end
		report_test($sformatf("frame %0d geometry", f), geo_errs);
		report_test($sformatf("frame %0d blanking", f), blk_errs);
		report_test($sformatf("frame %0d line colours", f), col_errs);
	endtask

	initial begin
		int f;
		seed      = 32'h9d06_6c2a;
		pass_cnt  = 0;
		fail_cnt  = 0;
		err_lines = 0;
		arst_n    = 1'b0;
		bar_cfg   = '0;
		load_stimulus(run_ok);
		if (run_ok) begin
			bar_cfg = cfgs[0];  // latched at the first wrap
		end else begin
			report_test("stimulus file", 1);
		end
		test_reset_state();
		if (run_ok) begin
			wait_vsync_fall(run_ok);
			if (!run_ok) begin
				report_test("first vsync", 1);
			end
		end
		if (run_ok) begin
			for (f = 0; f < cfgs.size(); f++) begin
				walk_frame(f);
			end
		end
		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (run_ok && fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
